//--- logic/frontend_pkg.sv
package frontend_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int FETCH_WIDTH = 4;
    localparam int SLOT_BITS = $clog2(FETCH_WIDTH);
    // Byte offset inside one cache line
    localparam int LINE_OFFSET_BITS = $clog2(FETCH_WIDTH * 4);

    localparam logic [5:0] OPC_B = 6'b010100;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef word_t [FETCH_WIDTH-1:0] line_t;

    // Raw word or B-format view of the same word
    typedef union packed {
        word_t raw;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } b;
    } instr_word_u;

    typedef struct packed {
        addr_t                start_pc;
        logic [SLOT_BITS:0]   length;
        logic                 pred_taken;
        logic [SLOT_BITS-1:0] pred_slot;
        addr_t                pred_target;
    } fetch_block_t;

    typedef struct packed {
        logic  valid;
        addr_t branch_pc;
        addr_t target;
    } btb_update_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } icache_req_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
        logic  pred_taken;
    } instr_info_t;

    typedef instr_info_t [FETCH_WIDTH-1:0] fetch_packet_t;

endpackage

//--- logic/bpu.sv
`timescale 1ns/1ps

module bpu
    import frontend_pkg::*;
#(
    parameter int BTB_ENTRIES = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    input  addr_t        pc_i,
    input  btb_update_t  btb_update_i,
    output fetch_block_t block_o,
    output logic         redirect_o,
    output addr_t        redirect_pc_o
);

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = ADDR_WIDTH - LINE_OFFSET_BITS - IDX_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [SLOT_BITS-1:0] slot;
        addr_t                target;
    } btb_entry_t;

    btb_entry_t entries[BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] entry_valid;

    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    logic [SLOT_BITS-1:0] pc_slot;
    btb_entry_t rd_entry;
    logic hit;

    logic [IDX_BITS-1:0] wr_idx;
    btb_entry_t wr_entry;

    assign rd_idx = pc_i[LINE_OFFSET_BITS +: IDX_BITS];
    assign rd_tag = pc_i[ADDR_WIDTH-1 -: TAG_BITS];
    assign pc_slot = pc_i[2 +: SLOT_BITS];
    assign rd_entry = entries[rd_idx];

    // Branch must sit at or after the first fetched word
    assign hit = entry_valid[rd_idx] && (rd_entry.tag == rd_tag) && (rd_entry.slot >= pc_slot);

    always_comb begin : block_comb
        block_o.start_pc = pc_i;
        if (hit) begin
            block_o.length = {1'b0, rd_entry.slot} - {1'b0, pc_slot} + 1'b1;
            block_o.pred_taken = 1'b1;
            block_o.pred_slot = rd_entry.slot;
            block_o.pred_target = rd_entry.target;
        end else begin
            // Run to the end of the line
            block_o.length = (SLOT_BITS + 1)'(FETCH_WIDTH) - {1'b0, pc_slot};
            block_o.pred_taken = 1'b0;
            block_o.pred_slot = SLOT_BITS'(FETCH_WIDTH - 1);
            block_o.pred_target = '0;
        end
    end

    assign redirect_o = hit;
    assign redirect_pc_o = rd_entry.target;

    assign wr_idx = btb_update_i.branch_pc[LINE_OFFSET_BITS +: IDX_BITS];
    assign wr_entry.tag = btb_update_i.branch_pc[ADDR_WIDTH-1 -: TAG_BITS];
    assign wr_entry.slot = btb_update_i.branch_pc[2 +: SLOT_BITS];
    assign wr_entry.target = btb_update_i.target;

    always_ff @(posedge clk or negedge rst_n) begin : valid_ff
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (btb_update_i.valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin : entry_ff
        if (btb_update_i.valid) begin
            entries[wr_idx] <= wr_entry;
        end
    end

endmodule

//--- logic/ftq.sv
`timescale 1ns/1ps

module ftq
    import frontend_pkg::*;
#(
    parameter int FTQ_DEPTH = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush_i,
    input  fetch_block_t push_i,
    output logic         full_o,
    output fetch_block_t head_o,
    output logic         head_valid_o,
    input  logic         accept_i
);

    localparam int PTR_BITS = $clog2(FTQ_DEPTH);

    fetch_block_t queue[FTQ_DEPTH];

    // Extra top bit tells full from empty
    logic [PTR_BITS:0] head_q;
    logic [PTR_BITS:0] tail_q;
    logic empty;
    logic push_en;
    logic pop_en;

    assign empty = (head_q == tail_q);
    assign full_o = (head_q[PTR_BITS] != tail_q[PTR_BITS])
                 && (head_q[PTR_BITS-1:0] == tail_q[PTR_BITS-1:0]);

    // A new block comes from the predictor every cycle
    assign push_en = !full_o && !flush_i;
    assign pop_en = accept_i && !empty && !flush_i;

    assign head_o = queue[head_q[PTR_BITS-1:0]];
    assign head_valid_o = !empty;

    always_ff @(posedge clk or negedge rst_n) begin : ptr_ff
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_en) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin : queue_ff
        if (push_en) begin
            queue[tail_q[PTR_BITS-1:0]] <= push_i;
        end
    end

endmodule

//--- logic/instr_predecode.sv
`timescale 1ns/1ps

module instr_predecode
    import frontend_pkg::*;
(
    input  instr_word_u instr_i,
    input  addr_t       pc_i,
    output logic        is_jump_o,
    output addr_t       target_o
);

    logic [25:0] offs26;

    assign is_jump_o = (instr_i.b.opcode == OPC_B);

    // High field carries offset bits 25..16
    assign offs26 = {instr_i.b.offs_hi, instr_i.b.offs_lo};

    // Word offset, sign extended
    assign target_o = pc_i + {{4{offs26[25]}}, offs26, 2'b00};

endmodule

//--- logic/ifu.sv
`timescale 1ns/1ps

module ifu
    import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush_i,
    input  fetch_block_t  block_i,
    input  logic          block_valid_i,
    output logic          accept_o,
    output icache_req_t   icache_req_o,
    input  logic          icache_ack_i,
    input  logic          icache_valid_i,
    input  line_t         icache_rdata_i,
    input  logic          stall_i,
    output fetch_packet_t fetch_o,
    output logic          redirect_o,
    output addr_t         redirect_pc_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_OUT,
        S_DRAIN
    } ifu_state_e;

    ifu_state_e state_q;
    ifu_state_e state_d;

    fetch_block_t block_q;
    line_t line_q;

    logic [SLOT_BITS-1:0] slot_idx[FETCH_WIDTH];
    addr_t slot_pc[FETCH_WIDTH];
    instr_word_u slot_word[FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] slot_jump;
    addr_t slot_target[FETCH_WIDTH];

    fetch_packet_t packet;
    logic jump_found;
    addr_t jump_pc;
    logic consume;

    assign accept_o = (state_q == S_IDLE) && block_valid_i && !flush_i;

    assign icache_req_o.valid = (state_q == S_REQ);
    assign icache_req_o.addr = {block_q.start_pc[ADDR_WIDTH-1:LINE_OFFSET_BITS],
                                {LINE_OFFSET_BITS{1'b0}}};

    always_comb begin : next_state_comb
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept_o) begin
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                // An acked request always gets its response
                if (icache_ack_i) begin
                    state_d = flush_i ? S_DRAIN : S_WAIT;
                end else if (flush_i) begin
                    state_d = S_IDLE;
                end
            end
            S_WAIT: begin
                if (icache_valid_i) begin
                    state_d = flush_i ? S_IDLE : S_OUT;
                end else if (flush_i) begin
                    state_d = S_DRAIN;
                end
            end
            S_OUT: begin
                if (flush_i || !stall_i) begin
                    state_d = S_IDLE;
                end
            end
            S_DRAIN: begin
                if (icache_valid_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin : state_ff
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin : data_ff
        if (accept_o) begin
            block_q <= block_i;
        end
        if (state_q == S_WAIT && icache_valid_i) begin
            line_q <= icache_rdata_i;
        end
    end

    for (genvar g = 0; g < FETCH_WIDTH; g++) begin : gen_slot
        // Word index wraps inside the line
        assign slot_idx[g] = block_q.start_pc[2 +: SLOT_BITS] + SLOT_BITS'(g);
        assign slot_pc[g] = block_q.start_pc + addr_t'(4 * g);
        assign slot_word[g] = line_q[slot_idx[g]];

        instr_predecode u_predecode (
            .instr_i  (slot_word[g]),
            .pc_i     (slot_pc[g]),
            .is_jump_o(slot_jump[g]),
            .target_o (slot_target[g])
        );
    end

    always_comb begin : packet_comb
        packet = '0;
        jump_found = 1'b0;
        jump_pc = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!jump_found && (i < int'(block_q.length))) begin
                packet[i].valid = 1'b1;
                packet[i].pc = slot_pc[i];
                packet[i].instr = slot_word[i].raw;
                packet[i].pred_taken = block_q.pred_taken
                                    && (i == int'(block_q.length) - 1);
                // Missed B before the predicted slot ends the packet here
                if (slot_jump[i] && !packet[i].pred_taken) begin
                    jump_found = 1'b1;
                    jump_pc = slot_target[i];
                    packet[i].pred_taken = 1'b1;
                end
            end
        end
    end

    assign consume = (state_q == S_OUT) && !stall_i && !flush_i;

    assign fetch_o = (state_q == S_OUT && !flush_i) ? packet : '0;
    assign redirect_o = consume && jump_found;
    assign redirect_pc_o = jump_pc;

endmodule

//--- logic/frontend.sv
`timescale 1ns/1ps

module frontend
    import frontend_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h1c00_0000,
    parameter int BTB_ENTRIES = 16,
    parameter int FTQ_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush_i,
    input  addr_t         flush_pc_i,
    input  btb_update_t   btb_update_i,
    output icache_req_t   icache_req_o,
    input  logic          icache_ack_i,
    input  logic          icache_valid_i,
    input  line_t         icache_rdata_i,
    input  logic          stall_i,
    output fetch_packet_t fetch_o
);

    addr_t pc_q;
    addr_t next_pc;
    addr_t seq_pc;

    fetch_block_t bpu_block;
    logic bpu_redirect;
    addr_t bpu_redirect_pc;

    logic ftq_full;
    fetch_block_t ftq_head;
    logic ftq_head_valid;

    logic ifu_accept;
    logic ifu_redirect;
    addr_t ifu_redirect_pc;

    assign seq_pc = bpu_block.start_pc
                  + {{(ADDR_WIDTH - SLOT_BITS - 3){1'b0}}, bpu_block.length, 2'b00};

    always_comb begin : next_pc_comb
        if (flush_i) begin
            next_pc = flush_pc_i;
        end else if (ifu_redirect) begin
            next_pc = ifu_redirect_pc;
        end else if (ftq_full) begin
            next_pc = pc_q;
        end else if (bpu_redirect) begin
            next_pc = bpu_redirect_pc;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin : pc_ff
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    bpu #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_bpu (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_i         (pc_q),
        .btb_update_i (btb_update_i),
        .block_o      (bpu_block),
        .redirect_o   (bpu_redirect),
        .redirect_pc_o(bpu_redirect_pc)
    );

    // Predecode redirect empties the queue like a backend flush
    ftq #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_ftq (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i | ifu_redirect),
        .push_i      (bpu_block),
        .full_o      (ftq_full),
        .head_o      (ftq_head),
        .head_valid_o(ftq_head_valid),
        .accept_i    (ifu_accept)
    );

    ifu u_ifu (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .block_i       (ftq_head),
        .block_valid_i (ftq_head_valid),
        .accept_o      (ifu_accept),
        .icache_req_o  (icache_req_o),
        .icache_ack_i  (icache_ack_i),
        .icache_valid_i(icache_valid_i),
        .icache_rdata_i(icache_rdata_i),
        .stall_i       (stall_i),
        .fetch_o       (fetch_o),
        .redirect_o    (ifu_redirect),
        .redirect_pc_o (ifu_redirect_pc)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

//--- bench/frontend_checker.sv
`timescale 1ns/1ps

module frontend_checker
    import frontend_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input logic          flush_i,
    input logic          stall_i,
    input icache_req_t   icache_req_i,
    input logic          icache_ack_i,
    input fetch_packet_t fetch_i
);

    logic [FETCH_WIDTH-1:0] slot_valid;
    logic [FETCH_WIDTH-1:0] slot_valid_inc;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_valid[i] = fetch_i[i].valid;
        end
        slot_valid_inc = slot_valid + 1'b1;
    end

    // Only a flush may withdraw a pending request
    req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        icache_req_i.valid && !icache_ack_i && !flush_i
        |=> icache_req_i.valid && $stable(icache_req_i.addr))
        else $error("cache request dropped or changed before ack");

    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i && fetch_i[0].valid |=> $stable(fetch_i) || flush_i)
        else $error("fetch output changed while stalled");

    // Valid slots form a run from slot 0
    slot_order_a: assert property (@(posedge clk) disable iff (!rst_n)
        (slot_valid & slot_valid_inc) == '0)
        else $error("fetch slot valid without its predecessor");

endmodule

bind frontend frontend_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .stall_i     (stall_i),
    .icache_req_i(icache_req_o),
    .icache_ack_i(icache_ack_i),
    .fetch_i     (fetch_o)
);

//--- bench/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb
    import frontend_pkg::*;
();

    localparam addr_t RESET_PC = 32'h1c00_0000;
    localparam addr_t MEM_BYTES = 32'h0000_1000;
    localparam int MEM_WORDS = 1024;
    localparam int HALF_PERIOD = 10;
    localparam int TIMEOUT_CYCLES = 200;

    logic clk;
    logic rst_n;
    logic flush;
    addr_t flush_pc;
    btb_update_t btb_update;
    icache_req_t icache_req;
    logic icache_ack;
    logic icache_valid;
    line_t icache_rdata;
    logic stall;
    fetch_packet_t fetch;

    word_t mem[MEM_WORDS];
    logic [31:0] rng_state;
    instr_info_t consumed[$];
    logic consumed_last[$];
    int check_count;
    int error_count;
    int timeout_count;
    int ack_wait;
    int resp_wait;
    logic resp_pending;
    addr_t resp_addr;

    tb_clock #(.PERIOD_NS(2 * HALF_PERIOD)) u_clock (.clk_o(clk));

    frontend #(
        .RESET_PC   (RESET_PC),
        .BTB_ENTRIES(16),
        .FTQ_DEPTH  (4)
    ) i_frontend (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush),
        .flush_pc_i    (flush_pc),
        .btb_update_i  (btb_update),
        .icache_req_o  (icache_req),
        .icache_ack_i  (icache_ack),
        .icache_valid_i(icache_valid),
        .icache_rdata_i(icache_rdata),
        .stall_i       (stall),
        .fetch_o       (fetch)
    );

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [9:0] word_index(addr_t a);
        addr_t offs;
        offs = a - RESET_PC;
        return offs[11:2];
    endfunction

    // Outside the window the memory reads as zero
    function automatic word_t mem_word(addr_t a);
        if ((a - RESET_PC) < MEM_BYTES) begin
            return mem[word_index(a)];
        end
        return '0;
    endfunction

    function automatic line_t read_line(addr_t a);
        line_t l;
        for (int w = 0; w < FETCH_WIDTH; w++) begin
            l[w] = mem_word(a + addr_t'(4 * w));
        end
        return l;
    endfunction

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Instruction cache, one request at a time with random ack and data delays
    always @(negedge clk) begin : cache_model
        if (icache_ack) begin
            icache_ack = 1'b0;
            resp_pending = 1'b1;
            resp_wait = int'(next_rand() % 4);
        end
        icache_valid = 1'b0;
        if (resp_pending) begin
            if (resp_wait == 0) begin
                icache_valid = 1'b1;
                icache_rdata = read_line(resp_addr);
                resp_pending = 1'b0;
            end else begin
                resp_wait--;
            end
        end else if (icache_req.valid) begin
            if (ack_wait == 0) begin
                icache_ack = 1'b1;
                resp_addr = icache_req.addr;
                ack_wait = int'(next_rand() % 4);
            end else begin
                ack_wait--;
            end
        end
    end

    // Sampled just before the rising edge that consumes the slots
    always @(negedge clk) begin : slot_monitor
        int pushed;
        #(HALF_PERIOD - 1);
        pushed = 0;
        if (rst_n && !stall && !flush) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (fetch[i].valid) begin
                    consumed.push_back(fetch[i]);
                    consumed_last.push_back(1'b0);
                    pushed++;
                end
            end
            if (pushed > 0) begin
                consumed_last[consumed_last.size() - 1] = 1'b1;
            end
        end
    end

    task automatic take_slot(input string name, output instr_info_t slot, output logic last,
                             output logic ok);
        int waited;
        waited = 0;
        while (consumed.size() == 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        ok = (consumed.size() != 0);
        slot = '0;
        last = 1'b0;
        if (ok) begin
            slot = consumed.pop_front();
            last = consumed_last.pop_front();
        end else begin
            timeout_count++;
            $display("%s: no instruction was delivered within %0d cycles", name,
                     TIMEOUT_CYCLES);
        end
    endtask

    task automatic wait_output_valid(input string name, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            ok = fetch[0].valid;
            waited++;
        end
        if (!ok) begin
            timeout_count++;
            $display("%s: the fetch output never became valid", name);
        end
    endtask

    task automatic wait_request(input string name, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            ok = icache_req.valid;
            waited++;
        end
        if (!ok) begin
            timeout_count++;
            $display("%s: no cache request was issued within %0d cycles", name,
                     TIMEOUT_CYCLES);
        end
    endtask

    task automatic flush_to(input addr_t target);
        @(negedge clk);
        flush = 1'b1;
        flush_pc = target;
        stall = 1'b0;
        consumed.delete();
        consumed_last.delete();
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic hold_output();
        @(negedge clk);
        stall = 1'b1;
    endtask

    task automatic check_stream(input string name, input addr_t start, input int count);
        instr_info_t slot;
        logic last;
        logic ok;
        addr_t pc;
        pc = start;
        for (int i = 0; i < count; i++) begin
            take_slot(name, slot, last, ok);
            if (!ok) begin
                return;
            end
            check_addr(name, pc, slot.pc);
            check_word(name, mem_word(pc), slot.instr);
            check_flag(name, 1'b0, slot.pred_taken);
            pc = pc + 32'd4;
        end
    endtask

    task automatic sequential_fetch();
        check_stream("sequential fetch", RESET_PC, 24);
        hold_output();
    endtask

    task automatic trained_prediction();
        instr_info_t slot;
        logic last;
        logic ok;
        addr_t line_pc;
        addr_t branch_pc;
        addr_t target_pc;
        addr_t pc;
        line_pc = RESET_PC + 32'h200;
        branch_pc = RESET_PC + 32'h208;
        target_pc = RESET_PC + 32'h404;
        @(negedge clk);
        btb_update.valid = 1'b1;
        btb_update.branch_pc = branch_pc;
        btb_update.target = target_pc;
        @(negedge clk);
        btb_update = '0;
        flush_to(line_pc);
        for (pc = line_pc; pc <= branch_pc; pc = pc + 32'd4) begin
            take_slot("trained prediction", slot, last, ok);
            if (!ok) begin
                return;
            end
            check_addr("trained prediction", pc, slot.pc);
            check_word("trained prediction", mem_word(pc), slot.instr);
            check_flag("trained prediction", pc == branch_pc, slot.pred_taken);
            // Packet ends at the predicted branch
            check_flag("trained prediction", pc == branch_pc, last);
        end
        take_slot("trained prediction", slot, last, ok);
        if (ok) begin
            check_addr("trained prediction", target_pc, slot.pc);
            check_word("trained prediction", mem_word(target_pc), slot.instr);
        end
        hold_output();
    endtask

    task automatic predecode_redirect();
        instr_info_t slot;
        logic last;
        logic ok;
        logic [25:0] offs;
        addr_t jump_pc;
        addr_t target_pc;
        addr_t pc;
        jump_pc = RESET_PC + 32'h804;
        // Backward jump of 24 words
        offs = 26'(-24);
        target_pc = jump_pc - 32'd96;
        mem[word_index(jump_pc)] = {OPC_B, offs[15:0], offs[25:16]};
        flush_to(RESET_PC + 32'h800);
        for (pc = RESET_PC + 32'h800; pc <= jump_pc; pc = pc + 32'd4) begin
            take_slot("predecode redirect", slot, last, ok);
            if (!ok) begin
                return;
            end
            check_addr("predecode redirect", pc, slot.pc);
            check_word("predecode redirect", mem_word(pc), slot.instr);
            check_flag("predecode redirect", pc == jump_pc, last);
        end
        take_slot("predecode redirect", slot, last, ok);
        if (ok) begin
            check_addr("predecode redirect", target_pc, slot.pc);
            check_word("predecode redirect", mem_word(target_pc), slot.instr);
        end
        hold_output();
    endtask

    task automatic flush_mid_stream();
        logic ok;
        flush_to(RESET_PC + 32'ha00);
        check_stream("flush", RESET_PC + 32'ha00, 6);
        wait_request("flush", ok);
        // Old stream still has a line in flight here
        flush_to(RESET_PC + 32'hc08);
        check_stream("flush", RESET_PC + 32'hc08, 12);
        hold_output();
    endtask

    task automatic back_pressure();
        fetch_packet_t held;
        int hold_cycles;
        logic ok;
        flush_to(RESET_PC + 32'he00);
        for (int round = 0; round < 3; round++) begin
            wait_output_valid("back-pressure", ok);
            if (!ok) begin
                return;
            end
            stall = 1'b1;
            held = fetch;
            hold_cycles = 1 + int'(next_rand() % 8);
            repeat (hold_cycles) begin
                @(negedge clk);
                for (int i = 0; i < FETCH_WIDTH; i++) begin
                    check_flag("back-pressure", held[i].valid, fetch[i].valid);
                    check_addr("back-pressure", held[i].pc, fetch[i].pc);
                    check_word("back-pressure", held[i].instr, fetch[i].instr);
                    check_flag("back-pressure", held[i].pred_taken, fetch[i].pred_taken);
                end
            end
            stall = 1'b0;
        end
        check_stream("back-pressure", RESET_PC + 32'he00, 16);
        hold_output();
    endtask

    initial begin : main
        rst_n = 1'b0;
        flush = 1'b0;
        flush_pc = '0;
        btb_update = '0;
        icache_ack = 1'b0;
        icache_valid = 1'b0;
        icache_rdata = '0;
        stall = 1'b0;
        resp_pending = 1'b0;
        resp_addr = '0;
        ack_wait = 0;
        resp_wait = 0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        rng_state = 32'hb491_5199;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = next_rand();
            // Keep B opcodes out of the random image
            if (mem[i][31:26] == OPC_B) begin
                mem[i][26] = ~mem[i][26];
            end
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        sequential_fetch();
        trained_prediction();
        predecode_redirect();
        flush_mid_stream();
        back_pressure();
        $display("checks %0d, value errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/frontend_pkg.sv
logic/bpu.sv
logic/ftq.sv
logic/instr_predecode.sv
logic/ifu.sv
logic/frontend.sv
bench/tb_clock.sv
bench/frontend_checker.sv
bench/frontend_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: run clean

obj_dir/Vfrontend_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module frontend_tb -f filelist.f

run: obj_dir/Vfrontend_tb
	@out="$$(./obj_dir/Vfrontend_tb)"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir
